// File: common/imgproc_pkg.sv
package imgproc_pkg;

	////////////////////////////////////////
	// frame geometry and tracking
	localparam int COORD_W = 11;
	localparam logic [COORD_W-1:0] IMAGE_W = 11'd640; // pixels per line
	localparam logic [COORD_W-1:0] ROI_TOP = 11'd160; // first line that may be tracked
	localparam int RUN_LEN = 4; // consecutive detections before a pixel counts

	// hsv windows, bounds inclusive
	localparam logic [7:0] RED_HUE_MIN = 8'd5;
	localparam logic [7:0] RED_HUE_MAX = 8'd18;
	localparam logic [7:0] RED_SAT_MIN = 8'd178;
	localparam logic [7:0] RED_SAT_MAX = 8'd254;
	localparam logic [7:0] RED_VAL_MIN = 8'd83;
	localparam logic [7:0] RED_VAL_MAX = 8'd255;
	localparam logic [7:0] BLUE_HUE_MIN = 8'd60;
	localparam logic [7:0] BLUE_HUE_MAX = 8'd92;
	localparam logic [7:0] BLUE_SAT_MIN = 8'd60;
	localparam logic [7:0] BLUE_SAT_MAX = 8'd163;
	localparam logic [7:0] BLUE_VAL_MIN = 8'd46;
	localparam logic [7:0] BLUE_VAL_MAX = 8'd236;

	////////////////////////////////////////
	// stream and pixel types
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// start-of-packet word, type sits in the low nibble
	typedef struct packed {
		logic [19:0] reserved;
		logic [3:0]  ptype; // 0 is video
	} descriptor_t;

	typedef union packed {
		rgb_t        pix;
		descriptor_t desc;
	} pixel_word_u;

	typedef struct packed {
		pixel_word_u word;
		logic        sop;
		logic        eop;
	} stream_beat_t;

	typedef struct packed {
		logic [7:0] hue; // degrees / 2
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} coord_t;

	typedef struct packed {
		logic               found;
		logic [COORD_W-1:0] left;
		logic [COORD_W-1:0] right;
		logic [COORD_W-1:0] top;
		logic [COORD_W-1:0] bottom;
	} box_t;

	// min at the top of the range and max at zero, so the first hit sets both
	localparam box_t BOX_EMPTY = '{found: 1'b0, left: '1, right: '0, top: '1, bottom: '0};

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	////////////////////////////////////////
	// colours and register map
	localparam rgb_t RED_HIGHLIGHT = 24'hff0000;
	localparam rgb_t BLUE_HIGHLIGHT = 24'h0000ff;
	localparam rgb_t RED_COL_DEFAULT = 24'hff0000;
	localparam rgb_t BLUE_COL_DEFAULT = 24'h0000ff;
	localparam logic [31:0] CORE_ID = 32'h1234_eee2;

	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_ID = 3'd1;
	localparam logic [2:0] ADDR_RED_COL = 3'd2;
	localparam logic [2:0] ADDR_BLUE_COL = 3'd3;
	localparam logic [2:0] ADDR_RED_TL = 3'd4;
	localparam logic [2:0] ADDR_RED_BR = 3'd5;
	localparam logic [2:0] ADDR_BLUE_TL = 3'd6;
	localparam logic [2:0] ADDR_BLUE_BR = 3'd7;

endpackage

// File: verilog/pixel_stream_reg.sv
module pixel_stream_reg (
	input  logic                      clk,
	input  logic                      reset_n,
	input  imgproc_pkg::stream_beat_t beat_i,
	input  logic                      valid_i,
	output logic                      ready_o,
	output imgproc_pkg::stream_beat_t beat_o,
	output logic                      valid_o,
	input  logic                      ready_i
);

	imgproc_pkg::stream_beat_t beat_q;
	logic valid_q;

	// room when empty or when the held beat leaves this cycle
	assign ready_o = ~valid_q | ready_i;
	assign beat_o = beat_q;
	assign valid_o = valid_q;

	always_ff @(posedge clk) begin
		if (!reset_n)
			valid_q <= 1'b0;
		else if (ready_o)
			valid_q <= valid_i;
	end

	always_ff @(posedge clk) begin
		if (ready_o && valid_i)
			beat_q <= beat_i; // payload moves only with a valid beat
	end

	// a stalled beat must not change or vanish
	a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
		valid_o && !ready_i |=> valid_o && $stable(beat_o));

endmodule

// File: verilog/frame_scanner.sv
module frame_scanner (
	input  logic                      clk,
	input  logic                      reset_n,
	input  imgproc_pkg::stream_beat_t beat_i,
	input  logic                      accept_i,
	output imgproc_pkg::coord_t       coord_o,
	output logic                      is_video_o
);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			coord_o <= '0;
			is_video_o <= 1'b0;
		end
		else if (accept_i) begin
			if (beat_i.sop) begin
				// descriptor word, first pixel follows at 0,0
				coord_o <= '0;
				is_video_o <= (beat_i.word.desc.ptype == 4'h0);
			end
			else if (coord_o.x == imgproc_pkg::IMAGE_W - 11'd1) begin
				coord_o.x <= '0; // end of line
				coord_o.y <= coord_o.y + 11'd1;
			end
			else begin
				coord_o.x <= coord_o.x + 11'd1;
			end
		end
	end

	a_x_in_line: assert property (@(posedge clk) disable iff (!reset_n)
		coord_o.x < imgproc_pkg::IMAGE_W);

endmodule

// File: colour_detect/hsv_convert.sv
module hsv_convert (
	input  imgproc_pkg::rgb_t pixel_i,
	output imgproc_pkg::hsv_t hsv_o
);

	logic [7:0] r, g, b;
	logic [7:0] mx, mn, d;
	logic [7:0] diff;  // magnitude of the two other channels' difference
	logic       neg;   // subtract the offset from the sector base
	logic [8:0] base;  // sector centre in degrees
	logic [8:0] q;
	logic [8:0] h360;

	assign r = pixel_i.r;
	assign g = pixel_i.g;
	assign b = pixel_i.b;
	assign mx = (r >= g) ? ((r >= b) ? r : b) : ((g >= b) ? g : b);
	assign mn = (r <= g) ? ((r <= b) ? r : b) : ((g <= b) ? g : b);
	assign d = mx - mn;

	////////////////////////////////////////
	// hue sector, r wins ties then g
	always_comb begin
		if (mx == r) begin
			neg = (g < b);
			base = neg ? 9'd360 : 9'd0;
			diff = neg ? b - g : g - b;
		end
		else if (mx == g) begin
			neg = (b < r);
			base = 9'd120;
			diff = neg ? r - b : b - r;
		end
		else begin
			neg = (r < g);
			base = 9'd240;
			diff = neg ? g - r : r - g;
		end
	end

	always_comb begin
		q = '0;
		h360 = '0; // grey pixel
		if (d != 8'd0) begin
			q = 9'((14'd60 * 14'(diff)) / 14'(d));
			h360 = neg ? base - q : base + q;
		end
	end

	always_comb begin
		hsv_o.hue = h360[8:1];
		hsv_o.val = mx;
		if (mx == 8'd0)
			hsv_o.sat = 8'd0;
		else
			hsv_o.sat = 8'((16'(d) * 16'd255) / 16'(mx)); // truncated
	end

endmodule

// File: colour_detect/colour_classifier.sv
module colour_classifier (
	input  logic                clk,
	input  logic                reset_n,
	input  imgproc_pkg::hsv_t   hsv_i,
	input  imgproc_pkg::coord_t coord_i,
	input  logic                accept_i,
	output logic                red_hit_o,
	output logic                blue_hit_o
);

	logic red_det, blue_det, in_roi;
	logic [imgproc_pkg::RUN_LEN-2:0] red_hist, blue_hist; // previous detections, newest in bit 0

	function automatic logic in_window(
		input imgproc_pkg::hsv_t p,
		input logic [7:0] h_lo, input logic [7:0] h_hi,
		input logic [7:0] s_lo, input logic [7:0] s_hi,
		input logic [7:0] v_lo, input logic [7:0] v_hi
	);
		return (p.hue >= h_lo) && (p.hue <= h_hi) &&
			(p.sat >= s_lo) && (p.sat <= s_hi) &&
			(p.val >= v_lo) && (p.val <= v_hi);
	endfunction

	assign red_det = in_window(hsv_i,
		imgproc_pkg::RED_HUE_MIN, imgproc_pkg::RED_HUE_MAX,
		imgproc_pkg::RED_SAT_MIN, imgproc_pkg::RED_SAT_MAX,
		imgproc_pkg::RED_VAL_MIN, imgproc_pkg::RED_VAL_MAX);
	assign blue_det = in_window(hsv_i,
		imgproc_pkg::BLUE_HUE_MIN, imgproc_pkg::BLUE_HUE_MAX,
		imgproc_pkg::BLUE_SAT_MIN, imgproc_pkg::BLUE_SAT_MAX,
		imgproc_pkg::BLUE_VAL_MIN, imgproc_pkg::BLUE_VAL_MAX);

	assign in_roi = (coord_i.y >= imgproc_pkg::ROI_TOP);

	// history runs across line and frame ends
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			red_hist <= '0;
			blue_hist <= '0;
		end
		else if (accept_i) begin
			red_hist <= {red_hist[imgproc_pkg::RUN_LEN-3:0], red_det};
			blue_hist <= {blue_hist[imgproc_pkg::RUN_LEN-3:0], blue_det};
		end
	end

	assign red_hit_o = red_det & (&red_hist) & in_roi;
	assign blue_hit_o = blue_det & (&blue_hist) & in_roi;

endmodule

// File: box_tracker/box_tracker.sv
module box_tracker (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                hit_i,
	input  logic                accept_i,
	input  logic                sop_i,
	input  logic                eop_i,
	input  logic                is_video_i,
	input  imgproc_pkg::coord_t coord_i,
	output imgproc_pkg::box_t   box_o
);

	imgproc_pkg::box_t run_q;    // extents of the frame in progress
	imgproc_pkg::box_t run_next; // extents including the current beat

	////////////////////////////////////////
	// widen the running box on a hit
	always_comb begin
		run_next = run_q;
		if (hit_i) begin
			run_next.found = 1'b1;
			if (coord_i.x < run_q.left)
				run_next.left = coord_i.x;
			if (coord_i.x > run_q.right)
				run_next.right = coord_i.x;
			if (coord_i.y < run_q.top)
				run_next.top = coord_i.y;
			if (coord_i.y > run_q.bottom)
				run_next.bottom = coord_i.y;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run_q <= imgproc_pkg::BOX_EMPTY;
			box_o <= '0; // nothing found yet, no outline
		end
		else if (accept_i) begin
			if (sop_i) begin
				run_q <= imgproc_pkg::BOX_EMPTY; // new packet
			end
			else begin
				run_q <= run_next;
				// last pixel counts too, shown over the next frame
				if (eop_i && is_video_i)
					box_o <= run_next;
			end
		end
	end

endmodule

// File: verilog/overlay_mixer.sv
module overlay_mixer (
	input  imgproc_pkg::stream_beat_t beat_i,
	input  logic                      mode_i,
	input  logic                      is_video_i,
	input  imgproc_pkg::coord_t       coord_i,
	input  imgproc_pkg::box_t         red_box_i,
	input  imgproc_pkg::box_t         blue_box_i,
	input  imgproc_pkg::rgb_t         red_col_i,
	input  imgproc_pkg::rgb_t         blue_col_i,
	input  logic                      red_hit_i,
	input  logic                      blue_hit_i,
	output imgproc_pkg::stream_beat_t beat_o
);

	imgproc_pkg::rgb_t pix, new_pix;
	logic [7:0] grey;

	function automatic logic on_outline(
		input imgproc_pkg::box_t bx,
		input imgproc_pkg::coord_t c
	);
		return bx.found && (c.x == bx.left || c.x == bx.right ||
			c.y == bx.top || c.y == bx.bottom);
	endfunction

	assign pix = beat_i.word.pix;
	assign grey = {1'b0, pix.g[7:1]} + {2'b00, pix.r[7:2]} + {2'b00, pix.b[7:2]}; // max 253

	// outline beats highlight, red beats blue
	always_comb begin
		if (on_outline(red_box_i, coord_i))
			new_pix = red_col_i;
		else if (on_outline(blue_box_i, coord_i))
			new_pix = blue_col_i;
		else if (red_hit_i)
			new_pix = imgproc_pkg::RED_HIGHLIGHT;
		else if (blue_hit_i)
			new_pix = imgproc_pkg::BLUE_HIGHLIGHT;
		else
			new_pix = '{r: grey, g: grey, b: grey};
	end

	always_comb begin
		beat_o = beat_i;
		if (mode_i && !beat_i.sop && is_video_i)
			beat_o.word.pix = new_pix; // descriptors and other packets untouched
	end

endmodule

// File: verilog/imgproc_regs.sv
module imgproc_regs (
	input  logic                 clk,
	input  logic                 reset_n,
	input  imgproc_pkg::wb_req_t wb_req_i,
	output imgproc_pkg::wb_rsp_t wb_rsp_o,
	input  imgproc_pkg::box_t    red_box_i,
	input  imgproc_pkg::box_t    blue_box_i,
	output imgproc_pkg::rgb_t    red_col_o,
	output imgproc_pkg::rgb_t    blue_col_o
);

	logic        req;     // request seen and not yet acknowledged
	logic        ack_q;
	logic [31:0] rd_data;
	logic [31:0] rd_q;

	// corner word, horizontal in 26:16 and vertical in 10:0
	function automatic logic [31:0] corner(
		input logic [imgproc_pkg::COORD_W-1:0] h,
		input logic [imgproc_pkg::COORD_W-1:0] v
	);
		return {5'b0, h, 5'b0, v};
	endfunction

	assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q;
	assign wb_rsp_o = '{ack: ack_q, dat: rd_q};

	always_comb begin
		case (wb_req_i.adr)
			imgproc_pkg::ADDR_STATUS:   rd_data = {30'b0, blue_box_i.found, red_box_i.found};
			imgproc_pkg::ADDR_ID:       rd_data = imgproc_pkg::CORE_ID;
			imgproc_pkg::ADDR_RED_COL:  rd_data = {8'h00, red_col_o};
			imgproc_pkg::ADDR_BLUE_COL: rd_data = {8'h00, blue_col_o};
			imgproc_pkg::ADDR_RED_TL:   rd_data = corner(red_box_i.left, red_box_i.top);
			imgproc_pkg::ADDR_RED_BR:   rd_data = corner(red_box_i.right, red_box_i.bottom);
			imgproc_pkg::ADDR_BLUE_TL:  rd_data = corner(blue_box_i.left, blue_box_i.top);
			imgproc_pkg::ADDR_BLUE_BR:  rd_data = corner(blue_box_i.right, blue_box_i.bottom);
			default:                    rd_data = 32'h0;
		endcase
	end

	////////////////////////////////////////
	// single-cycle ack, write lands with it
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ack_q <= 1'b0;
			red_col_o <= imgproc_pkg::RED_COL_DEFAULT;
			blue_col_o <= imgproc_pkg::BLUE_COL_DEFAULT;
		end
		else begin
			ack_q <= req;
			if (req && wb_req_i.we) begin
				if (wb_req_i.adr == imgproc_pkg::ADDR_RED_COL)
					red_col_o <= wb_req_i.dat[23:0];
				if (wb_req_i.adr == imgproc_pkg::ADDR_BLUE_COL)
					blue_col_o <= wb_req_i.dat[23:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			rd_q <= rd_data;
	end

	// master must keep the cycle open until it sees ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		wb_rsp_o.ack |-> wb_req_i.cyc && wb_req_i.stb);

endmodule

// File: verilog/imgproc_top.sv
module imgproc_top (
	input  logic                      clk,
	input  logic                      reset_n,

	// video in
	input  imgproc_pkg::stream_beat_t sink_beat_i,
	input  logic                      sink_valid_i,
	output logic                      sink_ready_o,

	// video out
	output imgproc_pkg::stream_beat_t source_beat_o,
	output logic                      source_valid_o,
	input  logic                      source_ready_i,

	input  logic                      mode_i, // 1 = highlight and outline
	input  imgproc_pkg::wb_req_t      wb_req_i,
	output imgproc_pkg::wb_rsp_t      wb_rsp_o
);

	imgproc_pkg::stream_beat_t in_beat, mix_beat;
	logic in_valid, out_ready;
	logic accept; // in_reg beat moves into out_reg this cycle
	imgproc_pkg::coord_t coord;
	logic is_video;
	imgproc_pkg::hsv_t hsv;
	logic red_hit, blue_hit;
	imgproc_pkg::box_t red_box, blue_box;
	imgproc_pkg::rgb_t red_col, blue_col;

	assign accept = in_valid & out_ready;

	////////////////////////////////////////
	// stream registers
	pixel_stream_reg u_in_reg (
		.clk(clk), .reset_n(reset_n),
		.beat_i(sink_beat_i), .valid_i(sink_valid_i), .ready_o(sink_ready_o),
		.beat_o(in_beat), .valid_o(in_valid), .ready_i(out_ready)
	);

	pixel_stream_reg u_out_reg (
		.clk(clk), .reset_n(reset_n),
		.beat_i(mix_beat), .valid_i(in_valid), .ready_o(out_ready),
		.beat_o(source_beat_o), .valid_o(source_valid_o), .ready_i(source_ready_i)
	);

	////////////////////////////////////////
	// pixel path between the registers
	frame_scanner u_frame_scanner (
		.clk(clk), .reset_n(reset_n), .beat_i(in_beat), .accept_i(accept),
		.coord_o(coord), .is_video_o(is_video)
	);

	hsv_convert u_hsv_convert (.pixel_i(in_beat.word.pix), .hsv_o(hsv));

	colour_classifier u_colour_classifier (
		.clk(clk), .reset_n(reset_n), .hsv_i(hsv), .coord_i(coord), .accept_i(accept),
		.red_hit_o(red_hit), .blue_hit_o(blue_hit)
	);

	box_tracker u_red_box (
		.clk(clk), .reset_n(reset_n), .hit_i(red_hit), .accept_i(accept),
		.sop_i(in_beat.sop), .eop_i(in_beat.eop), .is_video_i(is_video),
		.coord_i(coord), .box_o(red_box)
	);

	box_tracker u_blue_box (
		.clk(clk), .reset_n(reset_n), .hit_i(blue_hit), .accept_i(accept),
		.sop_i(in_beat.sop), .eop_i(in_beat.eop), .is_video_i(is_video),
		.coord_i(coord), .box_o(blue_box)
	);

	overlay_mixer u_overlay_mixer (
		.beat_i(in_beat), .mode_i(mode_i), .is_video_i(is_video), .coord_i(coord),
		.red_box_i(red_box), .blue_box_i(blue_box),
		.red_col_i(red_col), .blue_col_i(blue_col),
		.red_hit_i(red_hit), .blue_hit_i(blue_hit), .beat_o(mix_beat)
	);

	imgproc_regs u_imgproc_regs (
		.clk(clk), .reset_n(reset_n), .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
		.red_box_i(red_box), .blue_box_i(blue_box),
		.red_col_o(red_col), .blue_col_o(blue_col)
	);

endmodule

// File: bench/imgproc_tb.sv
module imgproc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic        mode;
		logic [3:0]  ptype;
		logic [10:0] lines;
		logic [23:0] r_col;   // red rectangle colour and extents
		logic [10:0] rl, rr, rt, rb;
		logic [23:0] b_col;   // blue rectangle colour and extents
		logic [10:0] bl, br, bt, bb;
		logic [23:0] bg;
		logic        wr;      // register write before the frame
		logic [2:0]  wr_adr;
		logic [31:0] wr_dat;
		logic        rnd;     // random source_ready
	} frame_t;

	localparam int N_FRAMES = 6;
	frame_t frames [N_FRAMES] = '{
		'{1'b0, 4'h0, 11'd165, 24'hff6008, 11'd100, 11'd140, 11'd150, 11'd164,
			24'h64c896, 11'd300, 11'd350, 11'd158, 11'd164, 24'h808080, 1'b0, 3'd0, 32'h0, 1'b0},
		'{1'b1, 4'h5, 11'd161, 24'hff6008, 11'd10, 11'd60, 11'd160, 11'd161,
			24'h64c896, 11'd300, 11'd350, 11'd158, 11'd160, 24'h405060, 1'b0, 3'd0, 32'h0, 1'b0},
		'{1'b1, 4'h0, 11'd170, 24'hff6008, 11'd100, 11'd140, 11'd150, 11'd164,
			24'h64c896, 11'd300, 11'd350, 11'd158, 11'd164, 24'h808080, 1'b0, 3'd0, 32'h0, 1'b0},
		'{1'b1, 4'h0, 11'd168, 24'hff6008, 11'd200, 11'd260, 11'd161, 11'd166,
			24'h64c896, 11'd230, 11'd320, 11'd163, 11'd167, 24'h303030, 1'b1, 3'd2, 32'h00ff00, 1'b0},
		'{1'b1, 4'h0, 11'd162, 24'hff6008, 11'd20, 11'd30, 11'd140, 11'd161,
			24'h64c896, 11'd600, 11'd639, 11'd160, 11'd161, 24'h808080, 1'b1, 3'd3, 32'hffff00, 1'b0},
		'{1'b1, 4'h0, 11'd170, 24'hff6008, 11'd100, 11'd140, 11'd150, 11'd164,
			24'h64c896, 11'd300, 11'd350, 11'd158, 11'd164, 24'h808080, 1'b0, 3'd0, 32'h0, 1'b1}
	};

	logic clk = 1'b0;
	logic reset_n;
	imgproc_pkg::stream_beat_t sink_beat, source_beat;
	logic sink_valid, sink_ready, source_valid, source_ready, mode;
	imgproc_pkg::wb_req_t wb_req;
	imgproc_pkg::wb_rsp_t wb_rsp;

	integer seed = 32'h6b4f;
	logic rnd_ready;
	int mismatches, failures;
	imgproc_pkg::stream_beat_t expq[$];

	// reference model state
	logic [2:0] m_hist_r, m_hist_b;
	logic [10:0] m_x, m_y;
	logic m_video;
	imgproc_pkg::box_t m_run_r, m_run_b, m_box_r, m_box_b;
	logic [23:0] m_col_r, m_col_b;

	always #2 clk = ~clk;

	imgproc_top u_imgproc_top (
		.clk(clk), .reset_n(reset_n),
		.sink_beat_i(sink_beat), .sink_valid_i(sink_valid), .sink_ready_o(sink_ready),
		.source_beat_o(source_beat), .source_valid_o(source_valid),
		.source_ready_i(source_ready),
		.mode_i(mode), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp)
	);

	always @(posedge clk) begin
		logic use_rnd;
		use_rnd = rnd_ready;
		#1;
		source_ready = use_rnd ? (($random(seed) % 4) != 0) : 1'b1;
	end

	////////////////////////////////////////
	// source monitor samples mid-cycle
	always @(negedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (expq.size() == 0) begin
				$display("source produced a beat that was never sent");
				failures++;
			end
			else if (source_beat !== expq[0]) begin
				$display("mismatch source_beat_o: got %h expected %h", source_beat, expq[0]);
				mismatches++;
				void'(expq.pop_front());
			end
			else begin
				void'(expq.pop_front());
			end
		end
	end

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	function automatic imgproc_pkg::hsv_t to_hsv(input logic [23:0] p);
		int r, g, b, mx, mn, d, h;
		imgproc_pkg::hsv_t o;
		r = int'(p[23:16]);
		g = int'(p[15:8]);
		b = int'(p[7:0]);
		mx = (r > g) ? r : g;
		mx = (b > mx) ? b : mx;
		mn = (r < g) ? r : g;
		mn = (b < mn) ? b : mn;
		d = mx - mn;
		if (d == 0) h = 0;
		else if (mx == r) h = (g >= b) ? 60 * (g - b) / d : 360 - 60 * (b - g) / d;
		else if (mx == g) h = (b >= r) ? 120 + 60 * (b - r) / d : 120 - 60 * (r - b) / d;
		else h = (r >= g) ? 240 + 60 * (r - g) / d : 240 - 60 * (g - r) / d;
		o.hue = 8'(h / 2);
		o.sat = (mx == 0) ? 8'd0 : 8'(d * 255 / mx);
		o.val = 8'(mx);
		return o;
	endfunction

	function automatic logic inside_win(input logic [7:0] v, input logic [7:0] lo,
		input logic [7:0] hi);
		return v >= lo && v <= hi;
	endfunction

	function automatic logic on_edge(input imgproc_pkg::box_t bx, input logic [10:0] x,
		input logic [10:0] y);
		return bx.found && (x == bx.left || x == bx.right || y == bx.top || y == bx.bottom);
	endfunction

	function automatic imgproc_pkg::box_t widen(input imgproc_pkg::box_t bx,
		input logic [10:0] x, input logic [10:0] y);
		bx.found = 1'b1;
		if (x < bx.left) bx.left = x;
		if (x > bx.right) bx.right = x;
		if (y < bx.top) bx.top = y;
		if (y > bx.bottom) bx.bottom = y;
		return bx;
	endfunction

	////////////////////////////////////////
	// model of one accepted beat
	task automatic predict(input imgproc_pkg::stream_beat_t bt);
		imgproc_pkg::hsv_t h;
		imgproc_pkg::stream_beat_t o;
		logic dr, db, hr, hb;
		logic [7:0] gr;
		h = to_hsv(bt.word.pix);
		dr = inside_win(h.hue, 8'd5, 8'd18) && inside_win(h.sat, 8'd178, 8'd254) &&
			inside_win(h.val, 8'd83, 8'd255);
		db = inside_win(h.hue, 8'd60, 8'd92) && inside_win(h.sat, 8'd60, 8'd163) &&
			inside_win(h.val, 8'd46, 8'd236);
		hr = dr && (&m_hist_r) && m_y >= 11'd160;
		hb = db && (&m_hist_b) && m_y >= 11'd160;
		o = bt;
		if (mode && !bt.sop && m_video) begin
			gr = 8'(bt.word.pix.g / 2 + bt.word.pix.r / 4 + bt.word.pix.b / 4);
			if (on_edge(m_box_r, m_x, m_y)) o.word = m_col_r;
			else if (on_edge(m_box_b, m_x, m_y)) o.word = m_col_b;
			else if (hr) o.word = 24'hff0000;
			else if (hb) o.word = 24'h0000ff;
			else o.word = {gr, gr, gr};
		end
		expq.push_back(o);
		m_hist_r = {m_hist_r[1:0], dr};
		m_hist_b = {m_hist_b[1:0], db};
		if (bt.sop) begin
			m_run_r = '{1'b0, 11'h7ff, 11'h0, 11'h7ff, 11'h0};
			m_run_b = m_run_r;
			m_x = '0;
			m_y = '0;
			m_video = (bt.word.desc.ptype == 4'h0);
		end
		else begin
			if (hr) m_run_r = widen(m_run_r, m_x, m_y);
			if (hb) m_run_b = widen(m_run_b, m_x, m_y);
			if (bt.eop && m_video) begin
				m_box_r = m_run_r;
				m_box_b = m_run_b;
			end
			if (m_x == 11'd639) begin
				m_x = '0;
				m_y++;
			end
			else m_x++;
		end
	endtask

	task automatic send_beat(input imgproc_pkg::stream_beat_t bt);
		int t;
		sink_beat = bt;
		sink_valid = 1'b1;
		t = 0;
		@(negedge clk);
		while (!sink_ready) begin
			t++;
			if (t > 1000) give_up("sink_ready");
			@(negedge clk);
		end
		predict(bt);
		@(posedge clk);
		#1;
		sink_valid = 1'b0;
	endtask

	task automatic send_frame(input frame_t f);
		imgproc_pkg::stream_beat_t bt;
		int n, total;
		logic [10:0] px, py;
		total = f.lines * 640;
		bt.word.desc = '{reserved: 20'h0, ptype: f.ptype};
		bt.sop = 1'b1;
		bt.eop = 1'b0;
		send_beat(bt);
		for (n = 0; n < total; n++) begin
			px = 11'(n % 640);
			py = 11'(n / 640);
			bt.sop = 1'b0;
			bt.eop = (n == total - 1);
			bt.word.pix = f.bg;
			if (px >= f.rl && px <= f.rr && py >= f.rt && py <= f.rb) bt.word.pix = f.r_col;
			if (px >= f.bl && px <= f.br && py >= f.bt && py <= f.bb) bt.word.pix = f.b_col;
			send_beat(bt);
		end
	endtask

	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
		output logic [31:0] rd);
		int t;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		t = 0;
		@(negedge clk);
		while (!wb_rsp.ack) begin
			t++;
			if (t > 100) give_up("wishbone ack");
			@(negedge clk);
		end
		rd = wb_rsp.dat;
		@(posedge clk);
		#1;
		wb_req = '0;
	endtask

	function automatic logic [31:0] reg_model(input logic [2:0] adr);
		case (adr)
			3'd0: return {30'b0, m_box_b.found, m_box_r.found};
			3'd1: return 32'h1234eee2;
			3'd2: return {8'h0, m_col_r};
			3'd3: return {8'h0, m_col_b};
			3'd4: return {5'b0, m_box_r.left, 5'b0, m_box_r.top};
			3'd5: return {5'b0, m_box_r.right, 5'b0, m_box_r.bottom};
			3'd6: return {5'b0, m_box_b.left, 5'b0, m_box_b.top};
			default: return {5'b0, m_box_b.right, 5'b0, m_box_b.bottom};
		endcase
	endfunction

	initial begin
		logic [31:0] rd;
		int i, a, t;
		reset_n = 1'b0;
		sink_beat = '0;
		sink_valid = 1'b0;
		source_ready = 1'b1;
		mode = 1'b0;
		wb_req = '0;
		rnd_ready = 1'b0;
		mismatches = 0;
		failures = 0;
		m_hist_r = '0;
		m_hist_b = '0;
		m_x = '0;
		m_y = '0;
		m_video = 1'b0;
		m_run_r = '{1'b0, 11'h7ff, 11'h0, 11'h7ff, 11'h0};
		m_run_b = m_run_r;
		m_box_r = '0;
		m_box_b = '0;
		m_col_r = 24'hff0000;
		m_col_b = 24'h0000ff;
		repeat (10) @(posedge clk);
		#1;
		reset_n = 1'b1;

		for (i = 0; i < N_FRAMES; i++) begin
			if (frames[i].wr) begin
				wb_access(1'b1, frames[i].wr_adr, frames[i].wr_dat, rd);
				if (frames[i].wr_adr == 3'd2) m_col_r = frames[i].wr_dat[23:0];
				if (frames[i].wr_adr == 3'd3) m_col_b = frames[i].wr_dat[23:0];
			end
			mode = frames[i].mode;
			rnd_ready = frames[i].rnd;
			send_frame(frames[i]);
			t = 0;
			while (expq.size() != 0) begin // drain the pipeline
				t++;
				if (t > 10000) give_up("source beats to drain");
				@(posedge clk);
				#1;
			end
			rnd_ready = 1'b0;
			for (a = 0; a < 8; a++) begin
				wb_access(1'b0, 3'(a), 32'h0, rd);
				if (rd !== reg_model(3'(a))) begin
					$display("mismatch wb_rsp_o.dat at adr %0d: got %h expected %h",
						a, rd, reg_model(3'(a)));
					mismatches++;
				end
			end
		end

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: imgproc_top.f
common/imgproc_pkg.sv
verilog/pixel_stream_reg.sv
verilog/frame_scanner.sv
colour_detect/hsv_convert.sv
colour_detect/colour_classifier.sv
box_tracker/box_tracker.sv
verilog/overlay_mixer.sv
verilog/imgproc_regs.sv
verilog/imgproc_top.sv
bench/imgproc_tb.sv

// File: Makefile
TOP = imgproc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f imgproc_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f imgproc_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
